//--- hdl/aes_key_pkg.sv
////////////////////////////////////////
// AES key schedule package
// Key state types, configuration struct, Rcon start values
// and the GF(2^8) helpers shared by the key expansion blocks
////////////////////////////////////////

package aes_key_pkg;

  ////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////

  // One 32-bit key word, byte 0 in the low bits
  typedef logic [31:0] key_word_t;

  // Full key state, word 0 lowest, AES-128 uses words 0 to 3
  typedef key_word_t [7:0] full_key_t;

  // Round constant and round index
  typedef logic [7:0] rcon_t;
  typedef logic [3:0] round_t;

  // Direction of the key schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // Configuration seen by every block of the key expansion
  typedef struct packed {
    ciph_op_e op;
    key_len_e key_len;
    round_t   round;
  } key_cfg_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Rcon start values per direction and key length
  localparam rcon_t RCON_FWD_INIT     = 8'h01;
  localparam rcon_t RCON_INV_INIT_128 = 8'h36;
  localparam rcon_t RCON_INV_INIT_256 = 8'h40;

  // One S-box per byte of a key word
  localparam int NUM_SBOX = 4;

  // Reduction term of x^8 + x^4 + x^3 + x + 1
  localparam logic [7:0] AES_POLY_RED = 8'h1b;

  ////////////////////////////////////////
  // Helper functions
  ////////////////////////////////////////

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] aes_mul2(logic [7:0] in);
    return {in[6:0], 1'b0} ^ (in[7] ? AES_POLY_RED : 8'h00);
  endfunction

  // Divide by x, an odd input had the reduction term added
  function automatic logic [7:0] aes_div2(logic [7:0] in);
    logic [7:0] tmp;
    tmp = in[0] ? (in ^ AES_POLY_RED) : in;
    return {in[0], tmp[7:1]};
  endfunction

  // RotWord, lowest byte moves to the top
  function automatic key_word_t aes_rot_word(key_word_t in);
    return {in[7:0], in[31:8]};
  endfunction

endpackage

//--- hdl/aes_sbox_lut.sv
////////////////////////////////////////
// AES forward S-box
// Plain 256-entry lookup table, purely combinational
////////////////////////////////////////

`timescale 1ns/1ps

module aes_sbox_lut (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Forward substitution table, eight entries per line
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Byte value selects the table entry
  assign data_o = SBOX[data_i];

endmodule

//--- hdl/aes_rcon_gen.sv
////////////////////////////////////////
// AES round constant generator
// Holds Rcon, loads the start value on clear and steps
// it on every accepted round that consumes Rcon
////////////////////////////////////////

`timescale 1ns/1ps

module aes_rcon_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  aes_key_pkg::key_cfg_t cfg_i,
  input  logic                  clear_i,
  input  logic                  advance_i,
  output aes_key_pkg::rcon_t    rcon_o,
  output logic                  use_rcon_o
);

  import aes_key_pkg::*;

  rcon_t rcon_d;
  rcon_t rcon_q;
  rcon_t rcon_init;
  logic  rcon_we;

  // AES-256 even rounds only run SubWord, no Rcon
  assign use_rcon_o = ~((cfg_i.key_len == AES_256) & ~cfg_i.round[0]);

  // Start value depends on direction and, for inverse, key length
  always_comb begin : rcon_start
    if (cfg_i.op == CIPH_FWD) begin
      rcon_init = RCON_FWD_INIT;
    end else if (cfg_i.key_len == AES_128) begin
      rcon_init = RCON_INV_INIT_128;
    end else begin
      rcon_init = RCON_INV_INIT_256;
    end
  end

  // Clear has priority over stepping
  always_comb begin : rcon_next
    if (clear_i) begin
      rcon_d = rcon_init;
    end else if (cfg_i.op == CIPH_FWD) begin
      rcon_d = aes_mul2(rcon_q);
    end else begin
      rcon_d = aes_div2(rcon_q);
    end
  end

  // Rounds without Rcon must leave it untouched
  assign rcon_we = clear_i | (advance_i & use_rcon_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_rcon
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

endmodule

//--- hdl/aes_key_irregular.sv
////////////////////////////////////////
// AES key schedule irregular word
// RotWord, SubWord and Rcon addition on the selected key word
////////////////////////////////////////

`timescale 1ns/1ps

module aes_key_irregular (
  input  aes_key_pkg::key_cfg_t  cfg_i,
  input  aes_key_pkg::full_key_t key_i,
  input  aes_key_pkg::rcon_t     rcon_i,
  input  logic                   use_rcon_i,
  output aes_key_pkg::key_word_t irregular_o
);

  import aes_key_pkg::*;

  key_word_t rot_word_in;
  key_word_t rot_word_out;
  key_word_t sub_word_in;
  key_word_t sub_word_out;
  logic      use_rot_word;

  // Pick the word feeding RotWord
  always_comb begin : rot_word_in_mux
    unique case (cfg_i.key_len)
      AES_128: begin
        // Inverse rebuilds old word 3 of the previous key from words 3 and 2
        rot_word_in = (cfg_i.op == CIPH_INV) ? (key_i[3] ^ key_i[2]) : key_i[3];
      end
      AES_256: begin
        // Newest word of the older key sits at word 7 forward and word 3 walking back
        rot_word_in = (cfg_i.op == CIPH_FWD) ? key_i[7] : key_i[3];
      end
      default: rot_word_in = key_i[3];
    endcase
  end

  assign rot_word_out = aes_rot_word(rot_word_in);

  // Even AES-256 rounds skip RotWord
  assign use_rot_word = ~((cfg_i.key_len == AES_256) & ~cfg_i.round[0]);
  assign sub_word_in  = use_rot_word ? rot_word_out : rot_word_in;

  ////////////////////////////////////////
  // SubWord with one table per byte
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_SBOX; i++) begin : gen_sbox
    aes_sbox_lut u_aes_sbox (
      .data_i ( sub_word_in[8*i +: 8]  ),
      .data_o ( sub_word_out[8*i +: 8] )
    );
  end

  // Rcon only lands on the low byte
  always_comb begin : rcon_add
    irregular_o = sub_word_out;
    if (use_rcon_i) begin
      irregular_o[7:0] = sub_word_out[7:0] ^ rcon_i;
    end
  end

endmodule

//--- hdl/aes_key_words.sv
////////////////////////////////////////
// AES key schedule word chaining
// Combines the irregular word with the old key words into
// the next key state for each key length and direction
////////////////////////////////////////

`timescale 1ns/1ps

module aes_key_words (
  input  aes_key_pkg::key_cfg_t  cfg_i,
  input  aes_key_pkg::full_key_t key_i,
  input  aes_key_pkg::key_word_t irregular_i,
  output aes_key_pkg::full_key_t key_o
);

  import aes_key_pkg::*;

  full_key_t regular;

  always_comb begin : drive_regular
    // Halves swapped, reused where nothing else applies
    regular = {key_i[3:0], key_i[7:4]};

    unique case (cfg_i.key_len)

      ////////////////////////////////////////
      // AES-128
      ////////////////////////////////////////
      AES_128: begin
        // Upper words unused, keep the old lower words there
        regular[7:4] = key_i[3:0];
        regular[0]   = irregular_i ^ key_i[0];
        if (cfg_i.op == CIPH_FWD) begin
          // Each new word chains on the new word below it
          for (int i = 1; i < 4; i++) begin
            regular[i] = regular[i-1] ^ key_i[i];
          end
        end else begin
          // Walking back only needs neighbouring old words
          for (int i = 1; i < 4; i++) begin
            regular[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end

      ////////////////////////////////////////
      // AES-256
      ////////////////////////////////////////
      AES_256: begin
        if (cfg_i.round == '0) begin
          // First round only swaps halves, no new words
          regular = {key_i[3:0], key_i[7:4]};
        end else if (cfg_i.op == CIPH_FWD) begin
          // Old upper half moves down
          regular[3:0] = key_i[7:4];
          // New upper half starts from the irregular word
          regular[4] = irregular_i ^ key_i[0];
          for (int i = 1; i < 4; i++) begin
            regular[i+4] = regular[i+3] ^ key_i[i];
          end
        end else begin
          // Old lower half moves up
          regular[7:4] = key_i[3:0];
          // New lower half, word 0 from the irregular word
          regular[0] = irregular_i ^ key_i[4];
          for (int i = 0; i < 3; i++) begin
            regular[i+1] = key_i[4+i] ^ key_i[5+i];
          end
        end
      end

      default: regular = {key_i[3:0], key_i[7:4]};
    endcase
  end

  assign key_o = regular;

endmodule

//--- hdl/aes_key_expand.sv
////////////////////////////////////////
// AES round key expansion
// Next or previous round key for AES-128 and AES-256,
// key register kept by the caller, Rcon kept here
////////////////////////////////////////

`timescale 1ns/1ps

module aes_key_expand (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  output logic                   out_req_o,
  input  logic                   out_ack_i,
  input  logic                   clear_i,
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  aes_key_pkg::round_t    round_i,
  input  aes_key_pkg::full_key_t key_i,
  output aes_key_pkg::full_key_t key_o
);

  import aes_key_pkg::*;

  key_cfg_t  cfg;
  rcon_t     rcon;
  logic      use_rcon;
  logic      advance;
  key_word_t irregular;

  // Configuration bundle for the submodules
  assign cfg = '{op: op_i, key_len: key_len_i, round: round_i};

  // Lookup S-boxes answer in the same cycle
  assign out_req_o = en_i;

  // Round accepted when enabled, requesting and acknowledged
  assign advance = en_i & out_req_o & out_ack_i;

  aes_rcon_gen u_rcon_gen (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cfg_i      ( cfg      ),
    .clear_i    ( clear_i  ),
    .advance_i  ( advance  ),
    .rcon_o     ( rcon     ),
    .use_rcon_o ( use_rcon )
  );

  aes_key_irregular u_key_irregular (
    .cfg_i       ( cfg       ),
    .key_i       ( key_i     ),
    .rcon_i      ( rcon      ),
    .use_rcon_i  ( use_rcon  ),
    .irregular_o ( irregular )
  );

  aes_key_words u_key_words (
    .cfg_i       ( cfg       ),
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .key_o       ( key_o     )
  );

endmodule

//--- sim/aes_key_model.svh
////////////////////////////////////////
// AES key schedule reference model
// One forward or inverse key step per call and an S-box
// built from the GF(2^8) inverse and the affine map
////////////////////////////////////////

`ifndef AES_KEY_MODEL_SVH
`define AES_KEY_MODEL_SVH

// GF(2^8) product reduced by x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Affine map of x^254, which keeps zero at zero
function automatic logic [7:0] sbox_ref(logic [7:0] x);
  logic [7:0] inv;
  logic [7:0] sq;
  inv = 8'h01;
  sq  = x;
  for (int i = 1; i < 8; i++) begin
    sq  = gf_mul(sq, sq);
    inv = gf_mul(inv, sq);
  end
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
         {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic key_word_t sub_word_ref(key_word_t w);
  key_word_t s;
  for (int i = 0; i < 4; i++) begin
    s[8*i +: 8] = sbox_ref(w[8*i +: 8]);
  end
  return s;
endfunction

// Start value 01 forward and 36 or 40 walking back
function automatic rcon_t rcon_start_ref(ciph_op_e op, key_len_e len);
  if (op == CIPH_FWD) begin
    return 8'h01;
  end
  return (len == AES_128) ? 8'h36 : 8'h40;
endfunction

// Times 2 forward and times 8d backward since 8d is the inverse of 2
function automatic rcon_t rcon_step_ref(ciph_op_e op, rcon_t rc);
  return gf_mul(rc, (op == CIPH_FWD) ? 8'h02 : 8'h8d);
endfunction

// AES-256 even rounds skip Rcon
function automatic logic rcon_used_ref(key_len_e len, round_t rnd);
  return (len == AES_128) || rnd[0];
endfunction

function automatic full_key_t next_key_ref(ciph_op_e op, key_len_e len, round_t rnd,
                                           rcon_t rcon, full_key_t k);
  full_key_t n;
  key_word_t t;
  key_word_t w;
  n = '0;
  if (len == AES_128) begin
    // Inverse rebuilds the old word 3 from words 3 and 2
    t = (op == CIPH_FWD) ? k[3] : (k[3] ^ k[2]);
    t = sub_word_ref({t[7:0], t[31:8]});
    t[7:0] = t[7:0] ^ rcon;
    n[7:4] = k[3:0];
    n[0] = t ^ k[0];
    for (int i = 1; i < 4; i++) begin
      n[i] = (op == CIPH_FWD) ? (n[i-1] ^ k[i]) : (k[i-1] ^ k[i]);
    end
  end else if (rnd == 4'd0) begin
    n = {k[3:0], k[7:4]};
  end else begin
    // Newest word of the older key, on top forward and at word 3 walking back
    w = (op == CIPH_FWD) ? k[7] : k[3];
    // Odd rounds rotate and add Rcon while even rounds only substitute
    t = rnd[0] ? {w[7:0], w[31:8]} : w;
    t = sub_word_ref(t);
    if (rnd[0]) begin
      t[7:0] = t[7:0] ^ rcon;
    end
    if (op == CIPH_FWD) begin
      n[3:0] = k[7:4];
      n[4] = t ^ k[0];
      for (int i = 1; i < 4; i++) begin
        n[i+4] = n[i+3] ^ k[i];
      end
    end else begin
      n[7:4] = k[3:0];
      n[0] = t ^ k[4];
      for (int i = 0; i < 3; i++) begin
        n[i+1] = k[4+i] ^ k[5+i];
      end
    end
  end
  return n;
endfunction

`endif

//--- sim/tb_aes_key_expand.sv
////////////////////////////////////////
// Testbench for the AES round key expansion
// Holds the key register, tracks Rcon in a model and checks
// every enabled cycle against the FIPS-197 schedule rules
////////////////////////////////////////

`timescale 1ns/1ps

module tb_aes_key_expand;

  import aes_key_pkg::*;

  `include "aes_key_model.svh"

  localparam logic [31:0] SEED         = 32'h7d095f5b;
  localparam int          STEP_TIMEOUT = 64;
  localparam logic [127:0] FIPS_KEY    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] FIPS_LAST   = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

  logic      clk_i;
  logic      rst_ni;
  logic      en_i;
  logic      out_req_o;
  logic      out_ack_i;
  logic      clear_i;
  ciph_op_e  op_i;
  key_len_e  key_len_i;
  round_t    round_i;
  full_key_t key_o;

  full_key_t   key_q;
  full_key_t   load_val;
  logic        load_key;
  rcon_t       ref_rcon;
  full_key_t   exp_key;
  full_key_t   trace[$];
  logic [31:0] lcg_state;
  int          errors;
  logic        timed_out;

  aes_key_expand dut_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .en_i      ( en_i      ),
    .out_req_o ( out_req_o ),
    .out_ack_i ( out_ack_i ),
    .clear_i   ( clear_i   ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .round_i   ( round_i   ),
    .key_i     ( key_q     ),
    .key_o     ( key_o     )
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Key register and Rcon model
  ////////////////////////////////////////

  // Caller side key register that takes key_o on each accepted round
  always_ff @(posedge clk_i or negedge rst_ni) begin : key_reg
    if (!rst_ni) begin
      key_q <= '0;
    end else if (load_key) begin
      key_q <= load_val;
    end else if (en_i && out_req_o && out_ack_i) begin
      key_q <= key_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ref_rcon_reg
    if (!rst_ni) begin
      ref_rcon <= '0;
    end else if (clear_i) begin
      ref_rcon <= rcon_start_ref(op_i, key_len_i);
    end else if (en_i && out_req_o && out_ack_i && rcon_used_ref(key_len_i, round_i)) begin
      ref_rcon <= rcon_step_ref(op_i, ref_rcon);
    end
  end

  assign exp_key = next_key_ref(op_i, key_len_i, round_i, ref_rcon, key_q);

  req_follows_en: assert property (@(posedge clk_i) disable iff (!rst_ni) out_req_o == en_i)
    else begin
      errors++;
      $display("Error at %0t: out_req_o %b while en_i %b", $time, out_req_o, en_i);
    end

  key_matches_model: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                      en_i |-> (key_o == exp_key))
    else begin
      errors++;
      $display("Error at %0t: key_o %h expected %h", $time, key_o, exp_key);
    end

  // Without an acknowledge nothing may move
  key_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
                             (en_i && !out_ack_i) |=> $stable(key_o))
    else begin
      errors++;
      $display("Error at %0t: key_o changed under back-pressure", $time);
    end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic full_key_t random_key();
    full_key_t k;
    for (int i = 0; i < 8; i++) begin
      k[i] = next_rand();
    end
    return k;
  endfunction

  // FIPS byte 0 is the leftmost hex pair and sits in word 0 bits 7:0
  function automatic full_key_t fips_to_key(logic [127:0] v);
    logic [255:0] flat;
    flat = '0;
    for (int b = 0; b < 16; b++) begin
      flat[8*b +: 8] = v[127-8*b -: 8];
    end
    return full_key_t'(flat);
  endfunction

  function automatic full_key_t low_half(full_key_t k);
    return {128'h0, k[3:0]};
  endfunction

  task automatic expect_key(input string what, input full_key_t got, input full_key_t want);
    assert (got == want) else begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // Loads the key register and restarts Rcon in one cycle
  task automatic load_and_clear(input ciph_op_e op, input key_len_e len, input full_key_t key);
    op_i = op;
    key_len_i = len;
    load_val = key;
    load_key = 1'b1;
    clear_i = 1'b1;
    en_i = 1'b0;
    out_ack_i = 1'b0;
    @(posedge clk_i);
    #2;
    load_key = 1'b0;
    clear_i = 1'b0;
  endtask

  task automatic step_round(input int rnd, input bit back_pressure);
    int          waited;
    bit          done;
    logic [31:0] r;
    waited = 0;
    done = 1'b0;
    round_i = round_t'(rnd);
    en_i = 1'b1;
    while (!done && waited < STEP_TIMEOUT) begin
      r = next_rand();
      out_ack_i = back_pressure ? (r[7:6] != 2'b00) : 1'b1;
      @(posedge clk_i);
      #2;
      done = out_req_o && out_ack_i;
      waited++;
    end
    en_i = 1'b0;
    out_ack_i = 1'b0;
    if (!done) begin
      timed_out = 1'b1;
      $display("Timeout: round %0d not accepted within %0d cycles", rnd, STEP_TIMEOUT);
    end
  endtask

  // Counts up or down from first to last and records each new key
  task automatic run_rounds(input int first, input int last, input bit back_pressure);
    int rnd;
    int dir;
    trace.delete();
    dir = (last >= first) ? 1 : -1;
    rnd = first;
    while (!timed_out) begin
      step_round(rnd, back_pressure);
      trace.push_back(key_q);
      if (rnd == last) begin
        break;
      end
      rnd += dir;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : main
    full_key_t fips_key;
    full_key_t rkey;
    full_key_t want;
    full_key_t first_run[$];
    rcon_t     rc;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    en_i = 1'b0;
    out_ack_i = 1'b0;
    clear_i = 1'b0;
    op_i = CIPH_FWD;
    key_len_i = AES_128;
    round_i = '0;
    load_key = 1'b0;
    load_val = '0;
    lcg_state = SEED;
    errors = 0;
    timed_out = 1'b0;
    fips_key = fips_to_key(FIPS_KEY);

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    assert (out_req_o == 1'b0) else begin
      errors++;
      $display("Error at %0t: out_req_o high after reset with en_i low", $time);
    end

    // AES-128 forward from the FIPS-197 key
    load_and_clear(CIPH_FWD, AES_128, fips_key);
    run_rounds(1, 10, 1'b0);
    first_run = trace;
    expect_key("last AES-128 round key", low_half(key_q), fips_to_key(FIPS_LAST));

    // AES-128 inverse back to the cipher key
    load_and_clear(CIPH_INV, AES_128, fips_to_key(FIPS_LAST));
    run_rounds(10, 1, 1'b0);
    expect_key("AES-128 inverse result", low_half(key_q), fips_key);

    // AES-256 swap on round 0 and a forward run undone by an inverse run
    for (int n = 0; n < 2 && !timed_out; n++) begin
      rkey = random_key();
      load_and_clear(CIPH_FWD, AES_256, rkey);
      step_round(0, 1'b0);
      expect_key("AES-256 forward round 0", key_q, {rkey[3:0], rkey[7:4]});
      load_and_clear(CIPH_INV, AES_256, rkey);
      step_round(0, 1'b0);
      expect_key("AES-256 inverse round 0", key_q, {rkey[3:0], rkey[7:4]});
      load_and_clear(CIPH_FWD, AES_256, rkey);
      run_rounds(1, 14, 1'b0);
      load_and_clear(CIPH_INV, AES_256, key_q);
      run_rounds(14, 1, 1'b0);
      expect_key("AES-256 round trip", key_q, rkey);
    end

    // Final key under back-pressure shows that Rcon held
    for (int n = 0; n < 3 && !timed_out; n++) begin
      rkey = (n == 0) ? fips_key : random_key();
      want = rkey;
      rc = rcon_start_ref(CIPH_FWD, AES_128);
      for (int r = 1; r <= 10; r++) begin
        want = next_key_ref(CIPH_FWD, AES_128, round_t'(r), rc, want);
        rc = rcon_step_ref(CIPH_FWD, rc);
      end
      load_and_clear(CIPH_FWD, AES_128, rkey);
      run_rounds(1, 10, 1'b1);
      expect_key("final key under back-pressure", key_q, want);
    end

    // Clear in the middle of a run restarts the schedule
    load_and_clear(CIPH_FWD, AES_128, fips_key);
    run_rounds(1, 5, 1'b0);
    load_and_clear(CIPH_FWD, AES_128, fips_key);
    run_rounds(1, 10, 1'b0);
    assert (timed_out || trace.size() == first_run.size()) else begin
      errors++;
      $display("Error at %0t: restarted run has %0d steps, expected %0d", $time,
               trace.size(), first_run.size());
    end
    foreach (first_run[i]) begin
      if (i < trace.size()) begin
        expect_key("restarted run step", trace[i], first_run[i]);
      end
    end

    $display("Checks done: %0d errors, %0d timeouts", errors, timed_out ? 1 : 0);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+sim
hdl/aes_key_pkg.sv
hdl/aes_sbox_lut.sv
hdl/aes_rcon_gen.sv
hdl/aes_key_irregular.sv
hdl/aes_key_words.sv
hdl/aes_key_expand.sv
sim/tb_aes_key_expand.sv

//--- Makefile
# Verilator build for the AES key expansion testbench

TOP := tb_aes_key_expand

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	rm -f sim.log
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
